// ==== build.f ====
msg_pkg.sv
msg_write_stage.sv
msg_data_buf.sv
message_loc.sv
message_loc_cntrl.sv
msg_read_stage.sv
msg_store_top.sv
msg_store_chk.sv
tb_clk_gen.sv
tb_msg_store.sv

// ==== msg_patterns.txt ====
// 1 <len> <words..> writes a message; 2 <index> <len> <words..> reads and expects the words
// a read with len 0 expects one error beat; 3 <word> offers a first word to a full table; 0 ends
2 0 0
1 1 a5
1 2 10 11
1 3 20 21 22
2 1 2 10 11
2 5 0
1 4 30 31 32 33
1 5 40 41 42 43 44
1 6 50 51 52 53 54 55
2 5 6 50 51 52 53 54 55
2 0 1 a5
2 0 1 a5
1 3 60 61 62
1 2 70 71
1 4 80 81 82 83
1 1 90
2 9 1 90
3 ee
2 a 0
2 f 0
2 2 3 20 21 22
2 3 4 30 31 32 33
2 4 5 40 41 42 43 44
2 6 3 60 61 62
2 8 4 80 81 82 83
2 7 2 70 71
0

// ==== tb_msg_store.sv ====
`timescale 1ns/1ps

module tb_msg_store import msg_pkg::*; ();

	localparam int PAT_LEN  = 512;
	localparam int WAIT_MAX = 400;  // cycles any single handshake may take

	logic              clk;
	logic              rst;
	logic              in_valid_i;
	logic [WORD_W-1:0] in_data_i;
	logic              in_first_i;
	logic              in_last_i;
	logic              in_ready_o;
	logic              rd_valid_i;
	logic [IDX_W-1:0]  rd_index_i;
	logic              rd_ready_o;
	logic              out_valid_o;
	logic [WORD_W-1:0] out_data_o;
	logic              out_last_o;
	logic              out_err_o;
	logic              out_ready_i;

	logic [7:0]  pat_mem [PAT_LEN];
	logic [31:0] lfsr;
	int          cmd_count;
	int          stored;  // messages the store should hold by now

	tb_clk_gen tb_clk_gen_inst (.clk, .rst);

	msg_store_top msg_store_top_inst (
		.clk, .rst,
		.in_valid_i, .in_data_i, .in_first_i, .in_last_i, .in_ready_o,
		.rd_valid_i, .rd_index_i, .rd_ready_o,
		.out_valid_o, .out_data_o, .out_last_o, .out_err_o, .out_ready_i
	);

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // taps 32 22 2 1
		return {s[30:0], fb};
	endfunction

	function automatic int count_commands();
		int p;
		int n;
		p = 0;
		n = 0;
		while (pat_mem[p] == 8'h01 || pat_mem[p] == 8'h02 || pat_mem[p] == 8'h03) begin
			n++;
			case (pat_mem[p])
				8'h01:   p += 2 + pat_mem[p+1];
				8'h02:   p += 3 + pat_mem[p+2];
				default: p += 2;
			endcase
		end
		return n;
	endfunction

	// ####################
	// write side
	task automatic push_word(input logic [WORD_W-1:0] data, input logic first, input logic last);
		int waited;
		in_valid_i = 1'b1;
		in_data_i  = data;
		in_first_i = first;
		in_last_i  = last;
		waited     = 0;
		while (!in_ready_o) begin
			@(posedge clk);
			#1;
			waited++;
			assert (waited < WAIT_MAX)
				else stop_on_error("in_ready_o never rose while a word was offered");
		end
		@(posedge clk);  // the word transfers at this edge
		#1;
		in_valid_i = 1'b0;
	endtask

	task automatic write_message(input int base, input int len);
		for (int k = 0; k < len; k++)
			push_word(pat_mem[base + k], k == 0, k == len - 1);
		repeat (3) @(posedge clk);  // end pulse, commit, count update
		#1;
		stored++;
	endtask

	task automatic offer_when_full(input logic [WORD_W-1:0] data);
		assert (stored == NUM_MSG)
			else stop_on_error("full table test reached before the table was filled");
		in_valid_i = 1'b1;
		in_data_i  = data;
		in_first_i = 1'b1;
		in_last_i  = 1'b1;
		repeat (10) begin
			assert (!in_ready_o)
				else stop_on_error($sformatf("MISMATCH in_ready_o: got %h expected %h",
					in_ready_o, 1'b0));
			@(posedge clk);
			#1;
		end
		in_valid_i = 1'b0;
	endtask

	// ####################
	// read side
	task automatic read_and_check(input logic [7:0] idx, input int len, input int base);
		int               beats;
		int               k;
		int               cycles;
		logic [WORD_W-1:0] exp_data;
		beats      = (len == 0) ? 1 : len;
		k          = 0;
		cycles     = 0;
		rd_valid_i = 1'b1;
		rd_index_i = idx[IDX_W-1:0];
		while (!rd_ready_o) begin
			@(posedge clk);
			#1;
			cycles++;
			assert (cycles < WAIT_MAX) else stop_on_error("rd_ready_o never rose for a request");
		end
		@(posedge clk);  // request accepted here
		#1;
		rd_valid_i = 1'b0;
		cycles     = 0;
		while (k < beats) begin
			assert (!rd_ready_o)
				else stop_on_error($sformatf(
					"MISMATCH rd_ready_o during reply index %h: got %h expected %h",
					idx, rd_ready_o, 1'b0));
			lfsr        = lfsr_step(lfsr);
			out_ready_i = lfsr[0];
			if (out_valid_o && out_ready_i) begin
				exp_data = (len == 0) ? '0 : pat_mem[base + k];
				assert (out_data_o == exp_data)
					else stop_on_error($sformatf(
						"MISMATCH out_data_o index %h beat %0d: got %h expected %h",
						idx, k, out_data_o, exp_data));
				assert (out_last_o == (k == beats - 1))
					else stop_on_error($sformatf(
						"MISMATCH out_last_o index %h beat %0d: got %h expected %h",
						idx, k, out_last_o, k == beats - 1));
				assert (out_err_o == (len == 0))
					else stop_on_error($sformatf(
						"MISMATCH out_err_o index %h beat %0d: got %h expected %h",
						idx, k, out_err_o, len == 0));
				k++;
			end
			@(posedge clk);
			#1;
			cycles++;
			assert (cycles < WAIT_MAX) else stop_on_error("reply did not finish in time");
		end
		out_ready_i = 1'b0;
		assert (!out_valid_o)
			else stop_on_error($sformatf("MISMATCH out_valid_o after last beat: got %h expected %h",
				out_valid_o, 1'b0));
		assert (rd_ready_o)
			else stop_on_error($sformatf("MISMATCH rd_ready_o after last beat: got %h expected %h",
				rd_ready_o, 1'b1));
	endtask

	initial begin
		wait (msg_store_top_inst.msg_store_chk_inst.err_count != 0);
		stop_on_error("a concurrent assertion on the DUT ports failed");
	end

	initial begin
		wait (cmd_count > 0);
		repeat (cmd_count * 200 + 20) @(posedge clk);
		stop_on_error("watchdog expired before the pattern list finished");
	end

	initial begin
		int ptr;
		in_valid_i  = 1'b0;
		in_data_i   = '0;
		in_first_i  = 1'b0;
		in_last_i   = 1'b0;
		rd_valid_i  = 1'b0;
		rd_index_i  = '0;
		out_ready_i = 1'b0;
		lfsr        = 32'h9d9f;
		stored      = 0;
		cmd_count   = 0;
		$readmemh("msg_patterns.txt", pat_mem);
		cmd_count = count_commands();
		assert (cmd_count > 0) else stop_on_error("pattern file holds no commands");
		wait (rst === 1'b0);
		@(posedge clk);
		#1;
		ptr = 0;
		while (pat_mem[ptr] != 8'h00) begin
			case (pat_mem[ptr])
				8'h01: begin
					write_message(ptr + 2, pat_mem[ptr+1]);
					ptr += 2 + pat_mem[ptr+1];
				end
				8'h02: begin
					read_and_check(pat_mem[ptr+1], pat_mem[ptr+2], ptr + 3);
					ptr += 3 + pat_mem[ptr+2];
				end
				8'h03: begin
					offer_when_full(pat_mem[ptr+1]);
					ptr += 2;
				end
				default: stop_on_error("unknown command code in the pattern file");
			endcase
		end
		repeat (4) @(posedge clk);
		if (msg_store_top_inst.msg_store_chk_inst.err_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			stop_on_error("a concurrent assertion on the DUT ports failed");
		end
	end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

// ==== msg_store_chk.sv ====
`timescale 1ns/1ps

module msg_store_chk import msg_pkg::*; (
	input logic              clk,
	input logic              rst,
	input logic              in_ready_o,
	input logic              rd_ready_o,
	input logic              out_valid_o,
	input logic [WORD_W-1:0] out_data_o,
	input logic              out_last_o,
	input logic              out_err_o,
	input logic              out_ready_i
);

	int err_count = 0;  // the testbench watches this count

	hold_valid: assert property (@(posedge clk) disable iff (rst)
		out_valid_o && !out_ready_i |=> out_valid_o)
		else begin
			$error("out_valid_o dropped before the beat transferred");
			err_count++;
		end

	// a stalled beat keeps its payload
	hold_payload: assert property (@(posedge clk) disable iff (rst)
		out_valid_o && !out_ready_i |=>
			$stable(out_data_o) && $stable(out_last_o) && $stable(out_err_o))
		else begin
			$error("output payload changed during a stall");
			err_count++;
		end

	quiet_in_reset: assert property (@(posedge clk)
		rst |=> !out_valid_o && !in_ready_o && !rd_ready_o)
		else begin
			$error("an output handshake was active during reset");
			err_count++;
		end

endmodule

bind msg_store_top msg_store_chk msg_store_chk_inst (
	.clk         (clk),
	.rst         (rst),
	.in_ready_o  (in_ready_o),
	.rd_ready_o  (rd_ready_o),
	.out_valid_o (out_valid_o),
	.out_data_o  (out_data_o),
	.out_last_o  (out_last_o),
	.out_err_o   (out_err_o),
	.out_ready_i (out_ready_i)
);

// ==== msg_store_top.sv ====
`timescale 1ns/1ps

module msg_store_top import msg_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid_i,
	input  logic [WORD_W-1:0] in_data_i,
	input  logic              in_first_i,
	input  logic              in_last_i,
	output logic              in_ready_o,
	input  logic              rd_valid_i,
	input  logic [IDX_W-1:0]  rd_index_i,
	output logic              rd_ready_o,
	output logic              out_valid_o,
	output logic [WORD_W-1:0] out_data_o,
	output logic              out_last_o,
	output logic              out_err_o,
	input  logic              out_ready_i
);

	logic              wr_en;
	logic [BUF_AW-1:0] wr_addr;
	logic [WORD_W-1:0] wr_data;
	logic              start_message;
	logic [BUF_AW-1:0] start_addr;
	logic              end_message;
	logic [BUF_AW-1:0] end_addr;
	logic              full;
	logic [IDX_W-1:0]  msg_count;
	logic              re;
	logic [IDX_W-1:0]  read_index;
	logic [BUF_AW-1:0] loc_start;
	logic [BUF_AW-1:0] loc_end;
	logic              rd_en;
	logic [BUF_AW-1:0] rd_addr;
	logic [WORD_W-1:0] rd_data;

	msg_write_stage msg_write_stage_inst (
		.clk, .rst,
		.in_valid_i, .in_data_i, .in_first_i, .in_last_i, .in_ready_o,
		.full_i          (full),
		.wr_en_o         (wr_en),
		.wr_addr_o       (wr_addr),
		.wr_data_o       (wr_data),
		.start_message_o (start_message),
		.start_addr_o    (start_addr),
		.end_message_o   (end_message),
		.end_addr_o      (end_addr)
	);

	msg_data_buf msg_data_buf_inst (
		.clk,
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (wr_data),
		.rd_en_i   (rd_en),
		.rd_addr_i (rd_addr),
		.rd_data_o (rd_data)
	);

	message_loc_cntrl message_loc_cntrl_inst (
		.clk, .rst,
		.start_message_i (start_message),
		.start_addr_i    (start_addr),
		.end_message_i   (end_message),
		.end_addr_i      (end_addr),
		.re_i            (re),
		.read_index_i    (read_index),
		.full_o          (full),
		.msg_count_o     (msg_count),
		.start_o         (loc_start),
		.end_o           (loc_end)
	);

	msg_read_stage msg_read_stage_inst (
		.clk, .rst,
		.rd_valid_i, .rd_index_i, .rd_ready_o,
		.msg_count_i   (msg_count),
		.loc_re_o      (re),
		.loc_index_o   (read_index),
		.loc_start_i   (loc_start),
		.loc_end_i     (loc_end),
		.buf_rd_en_o   (rd_en),
		.buf_rd_addr_o (rd_addr),
		.buf_rd_data_i (rd_data),
		.out_valid_o, .out_data_o, .out_last_o, .out_err_o,
		.out_ready_i
	);

endmodule

// ==== msg_read_stage.sv ====
`timescale 1ns/1ps

module msg_read_stage import msg_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              rd_valid_i,
	input  logic [IDX_W-1:0]  rd_index_i,
	output logic              rd_ready_o,
	input  logic [IDX_W-1:0]  msg_count_i,
	output logic              loc_re_o,
	output logic [IDX_W-1:0]  loc_index_o,
	input  logic [BUF_AW-1:0] loc_start_i,
	input  logic [BUF_AW-1:0] loc_end_i,
	output logic              buf_rd_en_o,
	output logic [BUF_AW-1:0] buf_rd_addr_o,
	input  logic [WORD_W-1:0] buf_rd_data_i,
	output logic              out_valid_o,
	output logic [WORD_W-1:0] out_data_o,
	output logic              out_last_o,
	output logic              out_err_o,
	input  logic              out_ready_i
);

	localparam logic [1:0] S_IDLE    = 2'd0;
	localparam logic [1:0] S_LOOKUP  = 2'd1;
	localparam logic [1:0] S_FETCH   = 2'd2;
	localparam logic [1:0] S_PRESENT = 2'd3;

	logic [1:0]        state;
	logic [1:0]        state_nxt;
	logic              accept;
	logic              next_fetch;
	logic              idx_err;
	logic              last_pend;   // the word in flight is the final one
	logic [BUF_AW-1:0] cur_addr;
	logic [BUF_AW-1:0] end_addr;
	logic [BUF_AW-1:0] next_addr;

	assign accept      = rd_valid_i && rd_ready_o;
	assign loc_re_o    = accept;  // table lookup starts in the request cycle
	assign loc_index_o = rd_index_i;
	assign next_addr   = cur_addr + 1'b1;
	assign next_fetch  = (state == S_PRESENT) && out_ready_i && !out_last_o;

	always_comb begin
		buf_rd_en_o   = next_fetch;
		buf_rd_addr_o = next_addr;
		if (state == S_LOOKUP && !idx_err) begin
			buf_rd_en_o   = 1'b1;
			buf_rd_addr_o = loc_start_i;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE:    if (accept) state_nxt = S_LOOKUP;
			S_LOOKUP:  state_nxt = idx_err ? S_PRESENT : S_FETCH;
			S_FETCH:   state_nxt = S_PRESENT;
			S_PRESENT: if (out_ready_i) state_nxt = out_last_o ? S_IDLE : S_FETCH;
			default:   state_nxt = S_IDLE;
		endcase
	end

	// ####################
	// control
	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= S_IDLE;
			rd_ready_o  <= 1'b0;
			out_valid_o <= 1'b0;
		end else begin
			state       <= state_nxt;
			rd_ready_o  <= (state_nxt == S_IDLE);
			out_valid_o <= (state_nxt == S_PRESENT);  // output register is full exactly then
		end
	end

	// ####################
	// addresses and output register
	always_ff @(posedge clk) begin
		if (accept)
			idx_err <= (rd_index_i >= msg_count_i);
		if (state == S_LOOKUP) begin
			cur_addr  <= loc_start_i;
			end_addr  <= loc_end_i;
			last_pend <= (loc_start_i == loc_end_i);
		end else if (next_fetch) begin
			cur_addr  <= next_addr;
			last_pend <= (next_addr == end_addr);
		end
		if (state == S_LOOKUP && idx_err) begin
			out_data_o <= '0;
			out_last_o <= 1'b1;
			out_err_o  <= 1'b1;
		end else if (state == S_FETCH) begin
			out_data_o <= buf_rd_data_i;
			out_last_o <= last_pend;
			out_err_o  <= 1'b0;
		end
	end

endmodule

// ==== message_loc_cntrl.sv ====
`timescale 1ns/1ps

module message_loc_cntrl import msg_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              start_message_i,
	input  logic [BUF_AW-1:0] start_addr_i,
	input  logic              end_message_i,
	input  logic [BUF_AW-1:0] end_addr_i,
	input  logic              re_i,
	input  logic [IDX_W-1:0]  read_index_i,
	output logic              full_o,
	output logic [IDX_W-1:0]  msg_count_o,
	output logic [BUF_AW-1:0] start_o,
	output logic [BUF_AW-1:0] end_o
);

	localparam logic [1:0] S_IDLE   = 2'd0;
	localparam logic [1:0] S_OPEN   = 2'd1;
	localparam logic [1:0] S_COMMIT = 2'd2;

	logic [1:0]        state;
	logic [IDX_W-1:0]  count;
	logic              store_start;
	logic              store_end;
	logic [BUF_AW-1:0] start_addr;
	logic [BUF_AW-1:0] end_addr;

	assign full_o      = (count == IDX_W'(NUM_MSG));
	assign msg_count_o = count;

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= S_IDLE;
			count       <= '0;
			store_start <= 1'b0;
			store_end   <= 1'b0;
		end else begin
			store_start <= 1'b0;
			store_end   <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start_message_i) begin
						store_start <= 1'b1;
						store_end   <= end_message_i;  // one-word message closes at once
						state       <= end_message_i ? S_COMMIT : S_OPEN;
					end
				end
				S_OPEN: begin
					if (end_message_i) begin
						store_end <= 1'b1;
						state     <= S_COMMIT;
					end
				end
				S_COMMIT: begin
					if (!full_o)
						count <= count + 1'b1;
					state <= S_IDLE;
					// the next message may already start while this one commits
					if (start_message_i) begin
						store_start <= 1'b1;
						store_end   <= end_message_i;
						state       <= end_message_i ? S_COMMIT : S_OPEN;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_message_i)
			start_addr <= start_addr_i;
		if (end_message_i)
			end_addr <= end_addr_i;
	end

	message_loc message_loc_inst (
		.clk,
		.rst,
		.start_i       (start_addr),
		.end_i         (end_addr),
		.store_start_i (store_start),
		.store_end_i   (store_end),
		.addr_i        (count),  // the slot is always the current count
		.re_i,
		.read_index_i,
		.start_o,
		.end_o
	);

endmodule

// ==== message_loc.sv ====
`timescale 1ns/1ps

module message_loc import msg_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic [BUF_AW-1:0] start_i,
	input  logic [BUF_AW-1:0] end_i,
	input  logic              store_start_i,
	input  logic              store_end_i,
	input  logic [IDX_W-1:0]  addr_i,
	input  logic              re_i,
	input  logic [IDX_W-1:0]  read_index_i,
	output logic [BUF_AW-1:0] start_o,
	output logic [BUF_AW-1:0] end_o
);

	logic [BUF_AW-1:0] start_mem [NUM_MSG];
	logic [BUF_AW-1:0] end_mem   [NUM_MSG];

	// slots past the table are never written
	always_ff @(posedge clk) begin
		if (store_start_i && addr_i < NUM_MSG)
			start_mem[addr_i] <= start_i;
		if (store_end_i && addr_i < NUM_MSG)
			end_mem[addr_i] <= end_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			start_o <= '0;
			end_o   <= '0;
		end else if (re_i && read_index_i < NUM_MSG) begin
			start_o <= start_mem[read_index_i];
			end_o   <= end_mem[read_index_i];
		end
	end

endmodule

// ==== msg_data_buf.sv ====
`timescale 1ns/1ps

module msg_data_buf import msg_pkg::*; (
	input  logic              clk,
	input  logic              wr_en_i,
	input  logic [BUF_AW-1:0] wr_addr_i,
	input  logic [WORD_W-1:0] wr_data_i,
	input  logic              rd_en_i,
	input  logic [BUF_AW-1:0] rd_addr_i,
	output logic [WORD_W-1:0] rd_data_o
);

	logic [WORD_W-1:0] mem [BUF_DEPTH];

	// ####################
	// write port
	always_ff @(posedge clk) begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// ####################
	// read port, one cycle of latency
	always_ff @(posedge clk) begin
		if (rd_en_i)
			rd_data_o <= mem[rd_addr_i];  // holds its value while not enabled
	end

endmodule

// ==== msg_write_stage.sv ====
`timescale 1ns/1ps

module msg_write_stage import msg_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid_i,
	input  logic [WORD_W-1:0] in_data_i,
	input  logic              in_first_i,
	input  logic              in_last_i,
	output logic              in_ready_o,
	input  logic              full_i,
	output logic              wr_en_o,
	output logic [BUF_AW-1:0] wr_addr_o,
	output logic [WORD_W-1:0] wr_data_o,
	output logic              start_message_o,
	output logic [BUF_AW-1:0] start_addr_o,
	output logic              end_message_o,
	output logic [BUF_AW-1:0] end_addr_o
);

	logic              run;     // low only in the cycle of reset
	logic              in_msg;  // a message has started and not yet ended
	logic [BUF_AW:0]   wr_ptr;  // one extra bit so the pointer can reach the depth
	logic              buf_full;
	logic              xfer;

	assign buf_full   = (wr_ptr == (BUF_AW+1)'(BUF_DEPTH));
	assign in_ready_o = run && !buf_full && !(full_i && !in_msg);  // table full blocks only a new message
	assign xfer       = in_valid_i && in_ready_o;

	assign wr_en_o   = xfer;
	assign wr_addr_o = wr_ptr[BUF_AW-1:0];
	assign wr_data_o = in_data_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			run             <= 1'b0;
			in_msg          <= 1'b0;
			wr_ptr          <= '0;
			start_message_o <= 1'b0;
			end_message_o   <= 1'b0;
		end else begin
			run             <= 1'b1;
			start_message_o <= xfer && in_first_i;
			end_message_o   <= xfer && in_last_i;
			if (xfer) begin
				wr_ptr <= wr_ptr + 1'b1;
				in_msg <= !in_last_i;
			end
		end
	end

	// the event addresses travel with the pulses one cycle later
	always_ff @(posedge clk) begin
		if (xfer && in_first_i)
			start_addr_o <= wr_addr_o;
		if (xfer && in_last_i)
			end_addr_o <= wr_addr_o;
	end

endmodule

// ==== msg_pkg.sv ====
package msg_pkg;

	// ####################
	// data path
	localparam int WORD_W    = 8;   // bits per stored word
	localparam int BUF_AW    = 6;   // buffer address width
	localparam int BUF_DEPTH = 64;  // words in the linear buffer

	// ####################
	// message table
	localparam int NUM_MSG = 10;    // slots in the location table
	localparam int IDX_W   = 4;     // message index and count width

endpackage
